/* hw/shared_fifo_pkg.sv */
// Sizes and shared types for the two-FIFO shared RAM read crossbar
// Referenced by scoped name from every RTL block of the read path

package shared_fifo_pkg;

  // --------------------------------------------------
  // Logical FIFOs and RAM geometry
  // --------------------------------------------------

  localparam int NUM_FIFOS = 2;
  localparam int NUM_BANKS = 2;

  // Total entries over all banks
  localparam int DEPTH = 16;
  localparam int DATA_W = 8;

  // Global address covers the whole RAM
  localparam int ADDR_W = $clog2(DEPTH);

  // --------------------------------------------------
  // Bank helpers
  // --------------------------------------------------

  // Low address bits pick the bank
  localparam int BANK_SEL_W = $clog2(NUM_BANKS);

  // Remaining upper bits index inside a bank
  localparam int BANK_ADDR_W = ADDR_W - BANK_SEL_W;
  localparam int BANK_DEPTH = DEPTH / NUM_BANKS;

  // --------------------------------------------------
  // FIFO tags
  // --------------------------------------------------

  localparam int FIFO_ID_W = $clog2(NUM_FIFOS);

  // Tag carried with each read and kept as arbiter state
  typedef enum logic [FIFO_ID_W-1:0] {
    FIFO_A = 1'b0,
    FIFO_B = 1'b1
  } fifo_id_e;

endpackage

/* hw/rd_addr_steer.sv */
// Routes each FIFO's read address request to the bank picked by its low address bit
// Purely combinational; sits between the FIFO ports and the bank read ports

`timescale 1ns/1ps

module rd_addr_steer (
  input  logic [shared_fifo_pkg::NUM_FIFOS-1:0]                       rd_addr_valid,
  output logic [shared_fifo_pkg::NUM_FIFOS-1:0]                       rd_addr_ready,
  input  logic [shared_fifo_pkg::NUM_FIFOS-1:0][shared_fifo_pkg::ADDR_W-1:0] rd_addr,

  output logic [shared_fifo_pkg::NUM_BANKS-1:0][shared_fifo_pkg::NUM_FIFOS-1:0]
               bank_req_valid,
  input  logic [shared_fifo_pkg::NUM_BANKS-1:0][shared_fifo_pkg::NUM_FIFOS-1:0]
               bank_req_ready,
  output logic [shared_fifo_pkg::NUM_FIFOS-1:0][shared_fifo_pkg::BANK_ADDR_W-1:0]
               bank_req_addr
);

  // Bank selected by each FIFO's current address
  logic [shared_fifo_pkg::NUM_FIFOS-1:0][shared_fifo_pkg::BANK_SEL_W-1:0] fifo_bank;

  // --------------------------------------------------
  // Per-FIFO decode
  // --------------------------------------------------

  for (genvar f = 0; f < shared_fifo_pkg::NUM_FIFOS; f++) begin : gen_fifo
    assign fifo_bank[f] = rd_addr[f][shared_fifo_pkg::BANK_SEL_W-1:0];

    // Bank bits are dropped and the rest indexes inside the bank
    assign bank_req_addr[f] =
        rd_addr[f][shared_fifo_pkg::ADDR_W-1:shared_fifo_pkg::BANK_SEL_W];

    // Only the selected bank can accept this FIFO
    assign rd_addr_ready[f] = bank_req_ready[fifo_bank[f]][f];

    for (genvar b = 0; b < shared_fifo_pkg::NUM_BANKS; b++) begin : gen_bank
      assign bank_req_valid[b][f] =
          rd_addr_valid[f] && (fifo_bank[f] == shared_fifo_pkg::BANK_SEL_W'(b));
    end
  end

endmodule

/* hw/bank_ram.sv */
// One bank of the shared RAM with a write port and a registered read port
// Read data shows up one cycle after rd_en; contents are not initialized

`timescale 1ns/1ps

module bank_ram (
  input  logic                                   clk,

  input  logic                                   rd_en,
  input  logic [shared_fifo_pkg::BANK_ADDR_W-1:0] rd_addr,
  output logic [shared_fifo_pkg::DATA_W-1:0]      rd_data,

  input  logic                                   wr_en,
  input  logic [shared_fifo_pkg::BANK_ADDR_W-1:0] wr_addr,
  input  logic [shared_fifo_pkg::DATA_W-1:0]      wr_data
);

  logic [shared_fifo_pkg::DATA_W-1:0] mem [shared_fifo_pkg::BANK_DEPTH];

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------

  // Read samples before the write lands, so a same-entry
  // read and write in one cycle returns the old value
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

endmodule

/* hw/bank_read_port.sv */
// Read port for one RAM bank with round-robin arbitration between the FIFOs
// Grants in the request cycle and returns tagged data one cycle later

`timescale 1ns/1ps

module bank_read_port (
  input  logic                                   clk,
  input  logic                                   rst_n,

  // Requests steered to this bank
  input  logic [shared_fifo_pkg::NUM_FIFOS-1:0]  req_valid,
  output logic [shared_fifo_pkg::NUM_FIFOS-1:0]  req_ready,
  input  logic [shared_fifo_pkg::NUM_FIFOS-1:0][shared_fifo_pkg::BANK_ADDR_W-1:0]
               req_addr,

  // Bank write port
  input  logic                                   wr_en,
  input  logic [shared_fifo_pkg::BANK_ADDR_W-1:0] wr_addr,
  input  logic [shared_fifo_pkg::DATA_W-1:0]      wr_data,

  // Tagged return toward the data return stage
  output logic                                   ret_valid,
  output shared_fifo_pkg::fifo_id_e              ret_fifo,
  output logic [shared_fifo_pkg::DATA_W-1:0]      ret_data
);

  shared_fifo_pkg::fifo_id_e                last_grant;
  shared_fifo_pkg::fifo_id_e                grant_fifo;
  logic                                     grant_valid;
  logic                                     req_conflict;
  logic [shared_fifo_pkg::BANK_ADDR_W-1:0]  ram_rd_addr;

  // --------------------------------------------------
  // Round-robin arbiter
  // --------------------------------------------------

  assign grant_valid  = |req_valid;
  assign req_conflict = req_valid[shared_fifo_pkg::FIFO_A] &&
                        req_valid[shared_fifo_pkg::FIFO_B];

  always_comb begin
    if (req_conflict) begin
      // On a conflict the FIFO not served last time goes first
      if (last_grant == shared_fifo_pkg::FIFO_A) begin
        grant_fifo = shared_fifo_pkg::FIFO_B;
      end else begin
        grant_fifo = shared_fifo_pkg::FIFO_A;
      end
    end else if (req_valid[shared_fifo_pkg::FIFO_A]) begin
      grant_fifo = shared_fifo_pkg::FIFO_A;
    end else begin
      grant_fifo = shared_fifo_pkg::FIFO_B;
    end
  end

  // One-hot ready that stays zero when nobody asks
  always_comb begin
    req_ready = '0;
    if (grant_valid) begin
      req_ready[grant_fifo] = 1'b1;
    end
  end

  // Reset value makes FIFO_A win the first conflict
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_grant <= shared_fifo_pkg::FIFO_B;
    end else if (grant_valid) begin
      last_grant <= grant_fifo;
    end
  end

  // --------------------------------------------------
  // RAM access
  // --------------------------------------------------

  assign ram_rd_addr = req_addr[grant_fifo];

  bank_ram u_bank_ram (
    .clk     (clk),
    .rd_en   (grant_valid),
    .rd_addr (ram_rd_addr),
    .rd_data (ret_data),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  // --------------------------------------------------
  // Tag delay matched to the RAM read latency
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ret_valid <= 1'b0;
    end else begin
      ret_valid <= grant_valid;
    end
  end

  // Granted FIFO tag lines up with the RAM read data
  always_ff @(posedge clk) begin
    if (grant_valid) begin
      ret_fifo <= grant_fifo;
    end
  end

endmodule

/* hw/rd_data_return.sv */
// Merges the tagged bank returns into one data strobe per FIFO
// Combinational; relies on at most one bank returning to a FIFO per cycle

`timescale 1ns/1ps

module rd_data_return (
  input  logic [shared_fifo_pkg::NUM_BANKS-1:0]                          bank_ret_valid,
  input  shared_fifo_pkg::fifo_id_e [shared_fifo_pkg::NUM_BANKS-1:0]     bank_ret_fifo,
  input  logic [shared_fifo_pkg::NUM_BANKS-1:0][shared_fifo_pkg::DATA_W-1:0]
               bank_ret_data,

  output logic [shared_fifo_pkg::NUM_FIFOS-1:0]                          rd_data_valid,
  output logic [shared_fifo_pkg::NUM_FIFOS-1:0][shared_fifo_pkg::DATA_W-1:0] rd_data
);

  // hit[f][b] marks bank b returning data for FIFO f
  logic [shared_fifo_pkg::NUM_FIFOS-1:0][shared_fifo_pkg::NUM_BANKS-1:0] hit;

  // --------------------------------------------------
  // Demux by tag
  // --------------------------------------------------

  for (genvar f = 0; f < shared_fifo_pkg::NUM_FIFOS; f++) begin : gen_fifo
    for (genvar b = 0; b < shared_fifo_pkg::NUM_BANKS; b++) begin : gen_bank
      assign hit[f][b] = bank_ret_valid[b] &&
                         (bank_ret_fifo[b] == shared_fifo_pkg::fifo_id_e'(f));
    end

    assign rd_data_valid[f] = |hit[f];
  end

  // --------------------------------------------------
  // One-hot data mux per FIFO
  // --------------------------------------------------

  always_comb begin
    for (int f = 0; f < shared_fifo_pkg::NUM_FIFOS; f++) begin
      rd_data[f] = '0;
      for (int b = 0; b < shared_fifo_pkg::NUM_BANKS; b++) begin
        // AND-OR over a one-hot or zero select
        rd_data[f] = rd_data[f] | ({shared_fifo_pkg::DATA_W{hit[f][b]}} & bank_ret_data[b]);
      end
    end
  end

endmodule

/* hw/shared_read_xbar_top.sv */
// Top of the shared RAM read crossbar for two FIFOs over two banks
// Read handshake to rd_data_valid is one cycle; wr_* loads the RAM directly

`timescale 1ns/1ps

module shared_read_xbar_top (
  input  logic                                   clk,
  input  logic                                   rst_n,

  // Read address per FIFO
  input  logic [shared_fifo_pkg::NUM_FIFOS-1:0]  rd_addr_valid,
  output logic [shared_fifo_pkg::NUM_FIFOS-1:0]  rd_addr_ready,
  input  logic [shared_fifo_pkg::NUM_FIFOS-1:0][shared_fifo_pkg::ADDR_W-1:0] rd_addr,

  // Read data per FIFO that cannot be stalled
  output logic [shared_fifo_pkg::NUM_FIFOS-1:0]  rd_data_valid,
  output logic [shared_fifo_pkg::NUM_FIFOS-1:0][shared_fifo_pkg::DATA_W-1:0] rd_data,

  // RAM load port
  input  logic                                   wr_valid,
  input  logic [shared_fifo_pkg::ADDR_W-1:0]      wr_addr,
  input  logic [shared_fifo_pkg::DATA_W-1:0]      wr_data
);

  logic [shared_fifo_pkg::NUM_BANKS-1:0][shared_fifo_pkg::NUM_FIFOS-1:0] bank_req_valid;
  logic [shared_fifo_pkg::NUM_BANKS-1:0][shared_fifo_pkg::NUM_FIFOS-1:0] bank_req_ready;
  logic [shared_fifo_pkg::NUM_FIFOS-1:0][shared_fifo_pkg::BANK_ADDR_W-1:0] bank_req_addr;

  logic [shared_fifo_pkg::NUM_BANKS-1:0]                          bank_ret_valid;
  shared_fifo_pkg::fifo_id_e [shared_fifo_pkg::NUM_BANKS-1:0]     bank_ret_fifo;
  logic [shared_fifo_pkg::NUM_BANKS-1:0][shared_fifo_pkg::DATA_W-1:0] bank_ret_data;

  logic [shared_fifo_pkg::NUM_BANKS-1:0]   bank_wr_en;
  logic [shared_fifo_pkg::BANK_ADDR_W-1:0] bank_wr_addr;

  // --------------------------------------------------
  // Write decode
  // --------------------------------------------------

  assign bank_wr_addr = wr_addr[shared_fifo_pkg::ADDR_W-1:shared_fifo_pkg::BANK_SEL_W];

  for (genvar b = 0; b < shared_fifo_pkg::NUM_BANKS; b++) begin : gen_wr_en
    assign bank_wr_en[b] = wr_valid &&
        (wr_addr[shared_fifo_pkg::BANK_SEL_W-1:0] == shared_fifo_pkg::BANK_SEL_W'(b));
  end

  // --------------------------------------------------
  // Read path
  // --------------------------------------------------

  rd_addr_steer u_rd_addr_steer (
    .rd_addr_valid  (rd_addr_valid),
    .rd_addr_ready  (rd_addr_ready),
    .rd_addr        (rd_addr),
    .bank_req_valid (bank_req_valid),
    .bank_req_ready (bank_req_ready),
    .bank_req_addr  (bank_req_addr)
  );

  bank_read_port bank0_port (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (bank_req_valid[0]),
    .req_ready (bank_req_ready[0]),
    .req_addr  (bank_req_addr),
    .wr_en     (bank_wr_en[0]),
    .wr_addr   (bank_wr_addr),
    .wr_data   (wr_data),
    .ret_valid (bank_ret_valid[0]),
    .ret_fifo  (bank_ret_fifo[0]),
    .ret_data  (bank_ret_data[0])
  );

  bank_read_port bank1_port (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (bank_req_valid[1]),
    .req_ready (bank_req_ready[1]),
    .req_addr  (bank_req_addr),
    .wr_en     (bank_wr_en[1]),
    .wr_addr   (bank_wr_addr),
    .wr_data   (wr_data),
    .ret_valid (bank_ret_valid[1]),
    .ret_fifo  (bank_ret_fifo[1]),
    .ret_data  (bank_ret_data[1])
  );

  rd_data_return u_rd_data_return (
    .bank_ret_valid (bank_ret_valid),
    .bank_ret_fifo  (bank_ret_fifo),
    .bank_ret_data  (bank_ret_data),
    .rd_data_valid  (rd_data_valid),
    .rd_data        (rd_data)
  );

endmodule

/* dv/tb_clock_gen.sv */
// Clock and reset source for the read crossbar testbench
// 10 ns clock; rst_n held low over the first 10 rising edges

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Release on a falling edge away from the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

/* dv/shared_read_xbar_asserts.sv */
// Protocol checks for the read crossbar bound into shared_read_xbar_top
// Covers the read address handshake, the return timing and the bank grants

`timescale 1ns/1ps

module shared_read_xbar_asserts (
  input logic                                   clk,
  input logic                                   rst_n,
  input logic [shared_fifo_pkg::NUM_FIFOS-1:0]  rd_addr_valid,
  input logic [shared_fifo_pkg::NUM_FIFOS-1:0]  rd_addr_ready,
  input logic [shared_fifo_pkg::NUM_FIFOS-1:0][shared_fifo_pkg::ADDR_W-1:0] rd_addr,
  input logic [shared_fifo_pkg::NUM_FIFOS-1:0]  rd_data_valid
);

  // --------------------------------------------------
  // Per-FIFO handshake
  // --------------------------------------------------

  for (genvar f = 0; f < shared_fifo_pkg::NUM_FIFOS; f++) begin : gen_fifo
    ready_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        rd_addr_ready[f] |-> rd_addr_valid[f])
      else $error("rd_addr_ready[%0d] high without rd_addr_valid", f);

    // Fixed one-cycle return
    data_after_handshake: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_addr_valid[f] && rd_addr_ready[f]) |=> rd_data_valid[f])
      else $error("no rd_data_valid[%0d] one cycle after handshake", f);

    addr_held_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_addr_valid[f] && !rd_addr_ready[f]) |=>
        (rd_addr_valid[f] && $stable(rd_addr[f])))
      else $error("rd_addr[%0d] dropped or changed while waiting", f);
  end

  // --------------------------------------------------
  // Bank grants
  // --------------------------------------------------

  // Both FIFOs ready together only when they sit on different banks
  one_grant_per_bank: assert property (@(posedge clk) disable iff (!rst_n)
      (rd_addr_ready[0] && rd_addr_ready[1]) |->
      (rd_addr[0][shared_fifo_pkg::BANK_SEL_W-1:0] !=
       rd_addr[1][shared_fifo_pkg::BANK_SEL_W-1:0]))
    else $error("bank %0d granted both FIFOs",
                rd_addr[0][shared_fifo_pkg::BANK_SEL_W-1:0]);

endmodule

bind shared_read_xbar_top shared_read_xbar_asserts u_asserts (
  .clk            (clk),
  .rst_n          (rst_n),
  .rd_addr_valid  (rd_addr_valid),
  .rd_addr_ready  (rd_addr_ready),
  .rd_addr        (rd_addr),
  .rd_data_valid  (rd_data_valid)
);

/* dv/shared_read_xbar_tb.sv */
// Testbench for shared_read_xbar_top with a reset check, a directed table and an LCG random phase
// Keeps a reference RAM and a round-robin model per bank to predict every response

`timescale 1ns/1ps

module shared_read_xbar_tb;

  typedef struct packed {
    logic       va;
    logic [3:0] aa;
    logic       vb;
    logic [3:0] ab;
    logic [1:0] exp_rdy;
  } row_t;

  logic                  clk;
  logic                  rst_n;
  logic [1:0]            rd_addr_valid;
  logic [1:0]            rd_addr_ready;
  logic [1:0][3:0]       rd_addr;
  logic [1:0]            rd_data_valid;
  logic [1:0][7:0]       rd_data;
  logic                  wr_valid;
  logic [3:0]            wr_addr;
  logic [7:0]            wr_data;

  logic [7:0]                ref_mem [16];
  shared_fifo_pkg::fifo_id_e model_last [2];
  row_t                      table_rows [$];
  logic [31:0]               lcg_state;
  int                        errors;
  int                        checks;
  logic                      timed_out;

  tb_clock_gen u_clock_gen (.clk(clk), .rst_n(rst_n));

  shared_read_xbar_top DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .rd_addr_valid (rd_addr_valid),
    .rd_addr_ready (rd_addr_ready),
    .rd_addr       (rd_addr),
    .rd_data_valid (rd_data_valid),
    .rd_data       (rd_data),
    .wr_valid      (wr_valid),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data)
  );

  // --------------------------------------------------
  // Reference models
  // --------------------------------------------------

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [7:0] fill_value(input int a);
    return 8'(a * 37) ^ 8'h5c;
  endfunction

  // Round-robin per bank where a lone requester wins and a conflict goes to the other FIFO
  function automatic logic [1:0] predict_ready(input logic [1:0] valid,
                                               input logic [1:0][3:0] addr);
    logic [1:0] rdy;
    logic       on_a;
    logic       on_b;
    rdy = 2'b00;
    for (int b = 0; b < 2; b++) begin
      on_a = valid[0] && (addr[0][0] == b[0]);
      on_b = valid[1] && (addr[1][0] == b[0]);
      if (on_a && on_b) begin
        if (model_last[b] == shared_fifo_pkg::FIFO_A) rdy[1] = 1'b1;
        else rdy[0] = 1'b1;
      end else if (on_a) begin
        rdy[0] = 1'b1;
      end else if (on_b) begin
        rdy[1] = 1'b1;
      end
    end
    return rdy;
  endfunction

  // --------------------------------------------------
  // Cycle driver and checks
  // --------------------------------------------------

  task automatic check_idle(input string when);
    checks++;
    assert (rd_addr_ready == 2'b00 && rd_data_valid == 2'b00) else begin
      errors++;
      $display("[FAIL] %0t: %s ready=%b data_valid=%b, expected both low",
               $time, when, rd_addr_ready, rd_data_valid);
    end
  endtask

  // Called at a falling edge with inputs driven and returns at the next falling edge
  task automatic run_cycle(output logic [1:0] hs, output logic [1:0] rdy);
    logic [1:0] pred;
    logic [7:0] exp_data [2];
    #1;
    rdy  = rd_addr_ready;
    pred = predict_ready(rd_addr_valid, rd_addr);
    checks++;
    assert (rdy == pred) else begin
      errors++;
      $display("[FAIL] %0t: rd_addr_ready=%b, model predicts %b", $time, rdy, pred);
    end
    hs = rd_addr_valid & rdy;
    for (int f = 0; f < 2; f++) exp_data[f] = ref_mem[rd_addr[f]];
    @(negedge clk);
    if (wr_valid) ref_mem[wr_addr] = wr_data;
    wr_valid = 1'b0;
    for (int f = 0; f < 2; f++) begin
      if (hs[f]) model_last[rd_addr[f][0]] = shared_fifo_pkg::fifo_id_e'(f);
      checks++;
      assert (rd_data_valid[f] == hs[f]) else begin
        errors++;
        $display("[FAIL] %0t: rd_data_valid[%0d]=%b, expected %b",
                 $time, f, rd_data_valid[f], hs[f]);
      end
      if (hs[f]) begin
        checks++;
        assert (rd_data[f] == exp_data[f]) else begin
          errors++;
          $display("[FAIL] %0t: FIFO %0d addr %h data %h, expected %h",
                   $time, f, rd_addr[f], rd_data[f], exp_data[f]);
        end
      end
    end
  endtask

  task automatic wait_reset_release();
    int waited;
    waited = 0;
    while (rst_n !== 1'b1 && waited < 30) begin
      @(posedge clk);
      #1;
      waited++;
      if (rst_n === 1'b1) check_idle("right after reset");
      else check_idle("during reset");
    end
    if (rst_n !== 1'b1) begin
      timed_out = 1'b1;
      $display("Timed out waiting for reset to be released");
    end else begin
      @(negedge clk);
    end
  endtask

  // --------------------------------------------------
  // Directed table
  // --------------------------------------------------

  task automatic build_table();
    // Same-bank conflicts right after reset with FIFO_A winning first each time
    table_rows.push_back({1'b1, 4'h0, 1'b1, 4'h2, 2'b01});
    table_rows.push_back({1'b1, 4'h4, 1'b1, 4'h6, 2'b01});
    table_rows.push_back({1'b1, 4'h1, 1'b1, 4'h3, 2'b01});
    table_rows.push_back({1'b1, 4'hb, 1'b1, 4'h9, 2'b01});
    // FIFO_A alone over every address
    for (int a = 0; a < 16; a++) table_rows.push_back({1'b1, 4'(a), 1'b0, 4'h0, 2'b01});
    // Different banks accepted together
    table_rows.push_back({1'b1, 4'h2, 1'b1, 4'h5, 2'b11});
    table_rows.push_back({1'b1, 4'h7, 1'b1, 4'h0, 2'b11});
    table_rows.push_back({1'b1, 4'hc, 1'b1, 4'hd, 2'b11});
    // Bank 0 last served FIFO_A above, so FIFO_B wins here
    table_rows.push_back({1'b1, 4'h8, 1'b1, 4'ha, 2'b10});
  endtask

  task automatic apply_row(input row_t row);
    logic [1:0] pend;
    logic [1:0] hs;
    logic [1:0] rdy;
    int         waited;
    pend          = {row.vb, row.va};
    rd_addr[0]    = row.aa;
    rd_addr[1]    = row.ab;
    rd_addr_valid = pend;
    waited        = 0;
    while (pend != 2'b00 && !timed_out) begin
      if (waited == 20) begin
        timed_out = 1'b1;
        $display("Timed out: no read handshake within 20 cycles for request mask %b", pend);
      end else begin
        run_cycle(hs, rdy);
        if (waited == 0) begin
          checks++;
          assert ((rdy & {row.vb, row.va}) == row.exp_rdy) else begin
            errors++;
            $display("[FAIL] %0t: first-cycle ready=%b, table expects %b",
                     $time, rdy, row.exp_rdy);
          end
        end
        pend          = pend & ~hs;
        rd_addr_valid = pend;
        waited++;
      end
    end
  endtask

  // --------------------------------------------------
  // Random phase
  // --------------------------------------------------

  task automatic random_phase();
    logic [31:0] r;
    logic [1:0]  hs;
    logic [1:0]  rdy;
    int          held [2];
    int          c;
    held[0] = 0;
    held[1] = 0;
    c       = 0;
    while ((c < 200 || rd_addr_valid != 2'b00) && !timed_out) begin
      for (int f = 0; f < 2; f++) begin
        if (!rd_addr_valid[f] && c < 200) begin
          r                = lcg_next();
          rd_addr_valid[f] = r[30];
          rd_addr[f]       = r[27:24];
        end
      end
      // Writes only to entries no FIFO is reading this cycle
      r        = lcg_next();
      wr_addr  = r[23:20];
      wr_data  = r[15:8];
      wr_valid = r[29] && !(rd_addr_valid[0] && rd_addr[0] == r[23:20]) &&
                 !(rd_addr_valid[1] && rd_addr[1] == r[23:20]);
      run_cycle(hs, rdy);
      rd_addr_valid = rd_addr_valid & ~hs;
      for (int f = 0; f < 2; f++) begin
        held[f] = rd_addr_valid[f] ? held[f] + 1 : 0;
        if (held[f] > 20 && !timed_out) begin
          timed_out = 1'b1;
          $display("Timed out: FIFO %0d request waited over 20 cycles in random phase", f);
        end
      end
      c++;
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial begin
    logic [1:0] hs;
    logic [1:0] rdy;
    rd_addr_valid = 2'b00;
    rd_addr       = '0;
    wr_valid      = 1'b0;
    wr_addr       = 4'h0;
    wr_data       = 8'h00;
    errors        = 0;
    checks        = 0;
    timed_out     = 1'b0;
    lcg_state     = 32'hb282;
    model_last[0] = shared_fifo_pkg::FIFO_B;
    model_last[1] = shared_fifo_pkg::FIFO_B;

    wait_reset_release();
    if (!timed_out) begin
      for (int a = 0; a < 16; a++) begin
        wr_valid = 1'b1;
        wr_addr  = 4'(a);
        wr_data  = fill_value(a);
        run_cycle(hs, rdy);
      end
      build_table();
      foreach (table_rows[i]) begin
        if (!timed_out) apply_row(table_rows[i]);
      end
      if (!timed_out) random_phase();
    end

    $display("Summary: %0d checks, %0d errors, timeout %0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* list.f */
hw/shared_fifo_pkg.sv
hw/rd_addr_steer.sv
hw/bank_ram.sv
hw/bank_read_port.sv
hw/rd_data_return.sv
hw/shared_read_xbar_top.sv
dv/tb_clock_gen.sv
dv/shared_read_xbar_asserts.sv
dv/shared_read_xbar_tb.sv

/* Bender.yml */
package:
  name: shared_read_xbar

sources:
  - files:
      - hw/shared_fifo_pkg.sv
      - hw/rd_addr_steer.sv
      - hw/bank_ram.sv
      - hw/bank_read_port.sv
      - hw/rd_data_return.sv
      - hw/shared_read_xbar_top.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/shared_read_xbar_asserts.sv
      - dv/shared_read_xbar_tb.sv
